//--- source/videoTimingPkg.sv
/*
  Raster constants and beam/video structs for a 320 x 264 frame with a
  256 x 224 visible area. Horizontal sync counts are raw counter values and
  only mean anything while horizontal blank is high.
*/
`default_nettype none

package videoTimingPkg;

    // Horizontal counter, 256 active + 64 blanked pixels per line
    localparam logic [7:0] HActiveEnd  = 8'hFF;  // Counter toggles blank here
    localparam logic [7:0] HBlankStart = 8'hC0;  // Reload on entering blank
    localparam logic [7:0] HSyncStart  = 8'hD6;  // Inside blank only
    localparam logic [7:0] HSyncEnd    = 8'hE5;
    localparam int         HbdDelay    = 8;      // DMA blank lag in pixels, power of two

    // Vertical line counter
    localparam int         LineWidth   = 9;
    localparam logic [8:0] VTotal      = 9'd264;
    localparam logic [8:0] VBlankStart = 9'd224;
    localparam logic [8:0] VSyncStart  = 9'd240;
    localparam logic [8:0] VSyncEnd    = 9'd243;  // Last sync line, inclusive

    // Timing PROM
    localparam int PromDepth     = 256;
    localparam int PromWidth     = 4;
    localparam int PromAddrWidth = $clog2(PromDepth);
    localparam int PromVStepBit  = 1;  // Rising edge steps the line counter

    // Raw beam position, one clock behind the counters
    typedef struct packed {
        logic [7:0]           hCnt;      // Raw horizontal count
        logic                 hb;        // Horizontal blank
        logic [LineWidth-1:0] line;      // Vertical line, 0..VTotal-1
        logic                 pxlValid;  // Sample taken in a pixel enable clock
    } beamPos_t;

    // Board-level video timing signals
    typedef struct packed {
        logic [7:0] H;      // Flipped horizontal position
        logic [7:0] V;      // Flipped vertical position
        logic       HB;
        logic       HBD_n;  // DMA blank, trails HB by HbdDelay pixels
        logic       VB;
        logic       HS;
        logic       VS;
        logic       SY_n;   // Composite sync
    } videoSig_t;

endpackage

`default_nettype wire

//--- source/apbPkg.sv
/*
  APB request/response structs and register map of the timing block.
  Offsets are word aligned on a 4-bit address; anything else is unmapped.
*/
`default_nettype none

package apbPkg;

    localparam int ApbAddrWidth = 4;
    localparam int ApbDataWidth = 8;

    // Register map
    localparam logic [ApbAddrWidth-1:0] RegCtrl     = 4'h0;  // Bit 0 flip
    localparam logic [ApbAddrWidth-1:0] RegPromAddr = 4'h4;  // PROM write pointer
    localparam logic [ApbAddrWidth-1:0] RegPromData = 4'h8;  // Write-only, auto increment
    localparam logic [ApbAddrWidth-1:0] RegLine     = 4'hC;  // Read-only, line[7:0]
    localparam int                      CtrlFlipBit = 0;

    typedef struct packed {
        logic                    PSEL;
        logic                    PENABLE;
        logic                    PWRITE;
        logic [ApbAddrWidth-1:0] PADDR;
        logic [ApbDataWidth-1:0] PWDATA;
    } apbReq_t;

    typedef struct packed {
        logic [ApbDataWidth-1:0] PRDATA;
        logic                    PREADY;
        logic                    PSLVERR;
    } apbResp_t;

endpackage

`default_nettype wire

//--- source/pixelClockEnable.sv
/*
  Pixel clock enable at a quarter of clk. One-clock pulse, low in reset,
  first pulse on the fourth clock after reset release.
*/
`timescale 1ns/1ps
`default_nettype none

module pixelClockEnable (
    input  logic clk,
    input  logic rst_n,
    output logic pxlCen  // One clock in four
);

    logic [1:0] divCnt;  // Free-running divider

    ////////////////////////////////////////
    // Divide by four
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            divCnt <= 2'd0;
            pxlCen <= 1'b0;
        end else begin
            divCnt <= divCnt + 2'd1;
            pxlCen <= &divCnt;  // Fires as the divider wraps
        end
    end

endmodule

`default_nettype wire

//--- source/apbRegBank.sv
/*
  APB slave, no wait states. Unmapped offsets and writes to the line
  register end with PSLVERR and leave state alone. PROM data writes go out
  as a one-clock strobe in the access cycle, then the pointer increments.
*/
`timescale 1ns/1ps
`default_nettype none

module apbRegBank
    import apbPkg::*;
    import videoTimingPkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  apbReq_t                  apbReq,
    output apbResp_t                 apbResp,
    input  logic [LineWidth-1:0]     beamLine,
    output logic                     flip,
    output logic [PromAddrWidth-1:0] promWrAddr,  // Also the readable pointer
    output logic [PromWidth-1:0]     promWrData,
    output logic                     promWe
);

    logic access;     // APB access phase
    logic wrAccess;
    logic mapped;
    logic badAccess;

    ////////////////////////////////////////
    // Decode
    always_comb begin
        access    = apbReq.PSEL & apbReq.PENABLE;
        wrAccess  = access & apbReq.PWRITE;
        mapped    = (apbReq.PADDR == RegCtrl)     || (apbReq.PADDR == RegPromAddr) ||
                    (apbReq.PADDR == RegPromData) || (apbReq.PADDR == RegLine);
        badAccess = access & (!mapped | (apbReq.PWRITE & (apbReq.PADDR == RegLine)));
    end

    assign promWe     = wrAccess & (apbReq.PADDR == RegPromData);
    assign promWrData = apbReq.PWDATA[PromWidth-1:0];  // Upper data bits dropped

    // Response, settles within the access cycle
    always_comb begin
        apbResp.PREADY  = 1'b1;  // Never stalls
        apbResp.PSLVERR = badAccess;
        apbResp.PRDATA  = '0;
        if (access && !apbReq.PWRITE) begin
            case (apbReq.PADDR)
                RegCtrl:     apbResp.PRDATA[CtrlFlipBit] = flip;
                RegPromAddr: apbResp.PRDATA = promWrAddr;
                RegLine:     apbResp.PRDATA = beamLine[ApbDataWidth-1:0];
                default:     apbResp.PRDATA = '0;  // PROM data reads as zero
            endcase
        end
    end

    ////////////////////////////////////////
    // Control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flip       <= 1'b0;
            promWrAddr <= '0;
        end else if (wrAccess) begin
            case (apbReq.PADDR)
                RegCtrl:     flip       <= apbReq.PWDATA[CtrlFlipBit];
                RegPromAddr: promWrAddr <= apbReq.PWDATA[PromAddrWidth-1:0];
                RegPromData: promWrAddr <= promWrAddr + 1'b1;  // Wraps at PromDepth
                default: ;  // Line and unmapped, no effect
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/timingProm.sv
/*
  256 x 4 timing PROM as a synchronous RAM loaded by the host.
  Read data is registered, one clock after the address. Contents start at
  zero; the output register refreshes every clock, so it is valid by the
  time reset is released.
*/
`timescale 1ns/1ps
`default_nettype none

module timingProm
    import videoTimingPkg::*;
(
    input  logic                     clk,
    input  logic [PromAddrWidth-1:0] rdAddr,
    output logic [PromWidth-1:0]     rdData,
    input  logic [PromAddrWidth-1:0] wrAddr,
    input  logic [PromWidth-1:0]     wrData,
    input  logic                     we
);

    // Unloaded PROM reads as all zeros
    logic [PromWidth-1:0] mem [PromDepth] = '{default: '0};

    ////////////////////////////////////////
    // Write port from the register bank, read port from the beam counter
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wrAddr] <= wrData;
        end
        rdData <= mem[rdAddr];  // Old data on a same-address write
    end

endmodule

`default_nettype wire

//--- source/beamCounter.sv
/*
  Horizontal and vertical beam counters. Counts move only in pixel enable
  clocks. The line counter advances on a rising edge of the PROM step bit,
  so it stands still until the PROM is loaded. Beam output is a registered
  copy of the counters, one clock behind.
*/
`timescale 1ns/1ps
`default_nettype none

module beamCounter
    import videoTimingPkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pxlCen,
    input  logic [PromWidth-1:0]     promData,
    output logic [PromAddrWidth-1:0] promAddr,
    output beamPos_t                 beam
);

    logic [7:0]           hCnt;
    logic                 hb;
    logic [LineWidth-1:0] line;
    logic                 vUp;      // PROM step bit
    logic                 vUpLast;  // Step bit at previous pixel
    logic                 vStep;

    ////////////////////////////////////////
    // Horizontal counter
    // 00..FF active, then C0..FF blanked: 320 pixels a line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hCnt <= 8'h00;
            hb   <= 1'b0;
        end else if (pxlCen) begin
            if (hCnt != HActiveEnd) begin
                hCnt <= hCnt + 8'd1;
            end else begin
                hb   <= ~hb;
                hCnt <= hb ? 8'h00 : HBlankStart;  // Leaving blank restarts at zero
            end
        end
    end

    // PROM sees blank plus the upper seven count bits, two pixels per entry
    assign promAddr = {hb, hCnt[7:1]};

    ////////////////////////////////////////
    // Vertical counter
    assign vUp   = promData[PromVStepBit];
    assign vStep = vUp & ~vUpLast;  // Rising edge only

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vUpLast <= 1'b0;
            line    <= '0;
        end else if (pxlCen) begin  // PROM data is stable by now
            vUpLast <= vUp;
            if (vStep) begin
                line <= (line == VTotal - 9'd1) ? '0 : line + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Beam sample, first pipeline stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beam <= '0;
        end else begin
            beam.hCnt     <= hCnt;
            beam.hb       <= hb;
            beam.line     <= line;
            beam.pxlValid <= pxlCen;  // Count as seen by the enable clock
        end
    end

endmodule

`default_nettype wire

//--- source/syncBlankGen.sv
/*
  Second pipeline stage: flipped position, blanks and syncs from the beam
  sample. Flip inverts H[7:3] and all of V, like the original board; H[2:0]
  is never flipped. Syncs are raw-count based and ignore flip.
*/
`timescale 1ns/1ps
`default_nettype none

module syncBlankGen
    import videoTimingPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  beamPos_t  beam,
    input  logic      flip,
    output videoSig_t video
);

    logic [7:0] hOut;       // Position after flip
    logic [7:0] vOut;
    logic       vbNext;
    logic       hsNext;
    logic       vsNext;
    logic       hbdTap;     // Last pixel of each HbdDelay group
    logic       hbSampled;  // HB seen at the previous tap

    ////////////////////////////////////////
    // Position and window decode
    always_comb begin
        hOut   = {beam.hCnt[7:3] ^ {5{flip}}, beam.hCnt[2:0]};
        vOut   = beam.line[7:0] ^ {8{flip}};
        vbNext = beam.line >= VBlankStart;
        vsNext = (beam.line >= VSyncStart) && (beam.line <= VSyncEnd);
        // Sync window only exists while blanking
        hsNext = beam.hb && (beam.hCnt >= HSyncStart) && (beam.hCnt <= HSyncEnd);
        hbdTap = beam.pxlValid && (beam.hCnt[2:0] == 3'(HbdDelay - 1));
    end

    ////////////////////////////////////////
    // DMA blank
    // HB resampled every HbdDelay pixels; the AND of both delays the start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hbSampled <= 1'b0;
        end else if (hbdTap) begin
            hbSampled <= beam.hb;
        end
    end

    ////////////////////////////////////////
    // Output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            video.H     <= 8'h00;
            video.V     <= 8'h00;
            video.HB    <= 1'b0;
            video.HBD_n <= 1'b1;
            video.VB    <= 1'b0;
            video.HS    <= 1'b0;
            video.VS    <= 1'b0;
            video.SY_n  <= 1'b1;
        end else begin
            video.H     <= hOut;
            video.V     <= vOut;
            video.HB    <= beam.hb;
            video.HBD_n <= ~(hbSampled & beam.hb);  // Ends together with HB
            video.VB    <= vbNext;
            video.HS    <= hsNext;
            video.VS    <= vsNext;
            video.SY_n  <= ~(hsNext | vsNext);      // Composite sync
        end
    end

endmodule

`default_nettype wire

//--- source/videoTimingTop.sv
/*
  Video timing subsystem. Video outputs trail the internal counters by two
  clocks and hold steady between pixel enables. Line stays at zero until the
  host loads the timing PROM over APB.
*/
`timescale 1ns/1ps
`default_nettype none

module videoTimingTop
    import apbPkg::*;
    import videoTimingPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apbReq_t   apbReq,
    output apbResp_t  apbResp,
    output videoSig_t video
);

    logic                     pxlCen;
    logic                     flip;
    logic [PromAddrWidth-1:0] promWrAddr;  // Host side of the PROM
    logic [PromWidth-1:0]     promWrData;
    logic                     promWe;
    logic [PromAddrWidth-1:0] promRdAddr;  // Beam side of the PROM
    logic [PromWidth-1:0]     promRdData;
    beamPos_t                 beam;

    pixelClockEnable i_pixelClockEnable (
        .clk    (clk),
        .rst_n  (rst_n),
        .pxlCen (pxlCen)
    );

    apbRegBank i_apbRegBank (
        .clk        (clk),
        .rst_n      (rst_n),
        .apbReq     (apbReq),
        .apbResp    (apbResp),
        .beamLine   (beam.line),
        .flip       (flip),
        .promWrAddr (promWrAddr),
        .promWrData (promWrData),
        .promWe     (promWe)
    );

    timingProm i_timingProm (
        .clk    (clk),
        .rdAddr (promRdAddr),
        .rdData (promRdData),
        .wrAddr (promWrAddr),
        .wrData (promWrData),
        .we     (promWe)
    );

    beamCounter i_beamCounter (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxlCen   (pxlCen),
        .promData (promRdData),
        .promAddr (promRdAddr),
        .beam     (beam)
    );

    syncBlankGen i_syncBlankGen (
        .clk   (clk),
        .rst_n (rst_n),
        .beam  (beam),
        .flip  (flip),
        .video (video)
    );

endmodule

`default_nettype wire

//--- verif/videoTimingTb.sv
/*
  Directed testbench for the video timing subsystem. Samples video on
  falling edges with one sample per pixel every 4 clocks. Pixel index 0 is
  the first blanked pixel of a line at raw count C0. The step entry sits in
  blank at raw count E0, so the line moves mid-blank and is steady at each HB rise.
*/
`timescale 1ns/1ps
`default_nettype none

module videoTimingTb
    import apbPkg::*;
    import videoTimingPkg::*;
();

    localparam int         ClkPeriod     = 100;
    localparam int         ResetCycles   = 4;
    localparam int         ClksPerPixel  = 4;
    localparam int         PixelsPerLine = 320;
    localparam int         BlankPixels   = 64;
    localparam logic [7:0] StepH         = 8'hE0;                // Raw count of the step entry
    localparam logic [7:0] StepAddr      = {1'b1, StepH[7:1]};   // Blank bit plus count[7:1]
    localparam int         StepPixel     = StepH - HBlankStart + 1;  // PROM data seen a pixel later
    // Two frames of pixels plus some lines for register traffic
    localparam int         TimeoutCycles = (2 * VTotal + 32) * PixelsPerLine * ClksPerPixel;

    logic      clk;
    logic      rst_n;
    apbReq_t   apbReq;
    apbResp_t  apbResp;
    videoSig_t video;
    int        cycleCount = 0;

    videoTimingTop i_videoTimingTop (
        .clk     (clk),
        .rst_n   (rst_n),
        .apbReq  (apbReq),
        .apbResp (apbResp),
        .video   (video)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    ////////////////////////////////////////
    // Error handling and timeout
    task automatic stopOnError(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic checkEq(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        string msg;
        if (expected !== actual) begin
            msg = $sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                            what, expected, actual);
            stopOnError(msg);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            stopOnError("Timeout: the tests did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////
    // APB host
    task automatic apbAccess(input logic write, input logic [3:0] addr, input logic [7:0] wdata,
                             output logic [7:0] rdata, output logic slverr);
        @(negedge clk);  // Setup cycle
        apbReq.PSEL    = 1'b1;
        apbReq.PENABLE = 1'b0;
        apbReq.PWRITE  = write;
        apbReq.PADDR   = addr;
        apbReq.PWDATA  = wdata;
        @(negedge clk);  // Access cycle
        apbReq.PENABLE = 1'b1;
        #(ClkPeriod / 10);  // Combinational response settles well before the rising edge
        checkEq("APB PREADY", 1, apbResp.PREADY);
        rdata  = apbResp.PRDATA;
        slverr = apbResp.PSLVERR;
        @(negedge clk);
        apbReq = '0;  // Back to idle
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [7:0] data, output logic slverr);
        logic [7:0] unused;
        apbAccess(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [7:0] data, output logic slverr);
        apbAccess(1'b0, addr, 8'h00, data, slverr);
    endtask

    // One step bit in the whole PROM gives one line step per line
    task automatic loadProm();
        logic       err;
        logic [7:0] value;
        apbWrite(RegPromAddr, 8'h00, err);
        checkEq("PROM address write PSLVERR", 0, err);
        for (int a = 0; a < PromDepth; a++) begin
            value = (a == StepAddr) ? 8'(1 << PromVStepBit) : 8'h00;
            apbWrite(RegPromData, value, err);  // Pointer auto increments
            checkEq("PROM data write PSLVERR", 0, err);
        end
    endtask

    ////////////////////////////////////////
    // Pixel stepping and raster model
    task automatic pixelStep();
        repeat (ClksPerPixel) @(negedge clk);
    endtask

    task automatic waitHbRise();
        logic prevHb;
        do begin
            prevHb = video.HB;
            pixelStep();
        end while (prevHb || !video.HB);
    endtask

    task automatic waitHbFall();
        logic prevHb;
        do begin
            prevHb = video.HB;
            pixelStep();
        end while (!prevHb || video.HB);
    endtask

    // Expected video for pixel k of a line counted from the HB rise
    task automatic checkPixel(input string testName, input int k, input int line,
                              input logic flipOn);
        logic [7:0] rawH;
        logic [7:0] hExp;
        logic [7:0] vExp;
        logic       hbExp;
        logic       hsExp;
        logic       vsExp;
        hbExp = (k < BlankPixels);
        rawH  = hbExp ? 8'(HBlankStart + k) : 8'(k - BlankPixels);  // C0..FF then 00..FF
        hsExp = hbExp && (rawH >= HSyncStart) && (rawH <= HSyncEnd);
        vsExp = (line >= VSyncStart) && (line <= VSyncEnd);
        hExp  = {rawH[7:3] ^ {5{flipOn}}, rawH[2:0]};
        vExp  = 8'(line) ^ {8{flipOn}};
        checkEq({testName, " H"}, hExp, video.H);
        checkEq({testName, " V"}, vExp, video.V);
        checkEq({testName, " HB"}, hbExp, video.HB);
        checkEq({testName, " HBD_n"}, !(hbExp && (k >= HbdDelay)), video.HBD_n);
        checkEq({testName, " VB"}, line >= VBlankStart, video.VB);
        checkEq({testName, " HS"}, hsExp, video.HS);
        checkEq({testName, " VS"}, vsExp, video.VS);
        checkEq({testName, " SY_n"}, !(hsExp || vsExp), video.SY_n);
    endtask

    // Checks a whole line and ends on the next HB rise sample
    task automatic scanLine(input string testName, input logic flipOn, input logic stepping,
                            inout int line);
        for (int k = 0; k < PixelsPerLine; k++) begin
            if (stepping && (k == StepPixel)) begin
                line = (line + 1) % VTotal;
            end
            checkPixel(testName, k, line, flipOn);
            pixelStep();
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    task automatic testRegisterAccess();
        logic [7:0] data;
        logic       err;
        apbWrite(RegCtrl, 8'h01, err);
        checkEq("register ctrl write PSLVERR", 0, err);
        apbRead(RegCtrl, data, err);
        checkEq("register flip set", 8'h01, data);
        apbWrite(RegCtrl, 8'h00, err);
        apbRead(RegCtrl, data, err);
        checkEq("register flip clear", 8'h00, data);
        apbWrite(4'h3, 8'hFF, err);  // Unmapped
        checkEq("register unmapped write PSLVERR", 1, err);
        apbWrite(RegLine, 8'hFF, err);  // Read-only
        checkEq("register line write PSLVERR", 1, err);
        apbRead(RegCtrl, data, err);
        checkEq("register flip after bad writes", 8'h00, data);
        apbWrite(RegPromAddr, 8'hA5, err);  // Nonzero pointer behind the data register
        checkEq("register PROM address write PSLVERR", 0, err);
        apbRead(RegPromData, data, err);
        checkEq("register PROM data read", 8'h00, data);
        checkEq("register PROM data read PSLVERR", 0, err);
        apbRead(RegPromAddr, data, err);
        checkEq("register PROM address readback", 8'hA5, data);
    endtask

    task automatic testLineLength();
        int   pixels;
        int   hbPixels;
        logic prevHb;
        waitHbRise();
        pixels   = 0;
        hbPixels = 0;
        do begin
            if (video.HB) begin
                hbPixels++;
            end
            prevHb = video.HB;
            pixelStep();
            pixels++;
        end while (prevHb || !video.HB);
        checkEq("line length pixels", PixelsPerLine, pixels);
        checkEq("line length blank pixels", BlankPixels, hbPixels);
    endtask

    task automatic testHsyncDmaBlank();
        int line;
        waitHbRise();
        line = 0;  // PROM still empty
        scanLine("hsync and DMA blank", 1'b0, 1'b0, line);
    endtask

    task automatic testVerticalStep();
        logic [7:0] data;
        logic       err;
        int         line;
        apbRead(RegLine, data, err);
        checkEq("vertical unloaded line", 8'h00, data);
        waitHbRise();
        waitHbRise();
        apbRead(RegLine, data, err);
        checkEq("vertical unloaded line after two lines", 8'h00, data);
        waitHbFall();  // Load fits in the active run before the step entry is read
        loadProm();
        waitHbRise();
        line = 0;
        while (line < VBlankStart) begin
            scanLine("vertical step", 1'b0, 1'b1, line);
        end
        checkEq("vertical V at blank start", VBlankStart, video.V);
        checkEq("vertical VB at blank start", 1, video.VB);
    endtask

    task automatic testFrame();
        int   line;
        int   rises;
        int   falls;
        int   vsLines;
        logic prevVb;
        line    = VBlankStart;  // Continues from the vertical test
        rises   = 0;
        falls   = 0;
        vsLines = 0;
        prevVb  = video.VB;
        for (int n = 0; n < VTotal; n++) begin
            scanLine("frame", 1'b0, 1'b1, line);
            if (video.VB && !prevVb) begin
                rises++;
            end
            if (!video.VB && prevVb) begin
                falls++;
            end
            if (video.VS) begin
                vsLines++;
            end
            prevVb = video.VB;
        end
        checkEq("frame VB rises", 1, rises);
        checkEq("frame VB falls", 1, falls);
        checkEq("frame VS lines", VSyncEnd - VSyncStart + 1, vsLines);
        checkEq("frame wraps to blank start", VBlankStart, video.V);
    endtask

    task automatic testFlip();
        logic err;
        int   line;
        apbWrite(RegCtrl, 8'h01, err);
        checkEq("flip write PSLVERR", 0, err);
        waitHbRise();
        line = VBlankStart + 1;  // One step since the frame test ended
        scanLine("flip", 1'b1, 1'b1, line);
        scanLine("flip", 1'b1, 1'b1, line);
        apbWrite(RegCtrl, 8'h00, err);
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        apbReq = '0;
        repeat (ResetCycles) @(negedge clk);
        checkEq("reset H", 8'h00, video.H);
        checkEq("reset HBD_n", 1, video.HBD_n);
        checkEq("reset SY_n", 1, video.SY_n);
        rst_n = 1'b1;

        testRegisterAccess();
        testLineLength();
        testHsyncDmaBlank();
        testVerticalStep();
        testFrame();
        testFlip();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
source/videoTimingPkg.sv
source/apbPkg.sv
source/pixelClockEnable.sv
source/apbRegBank.sv
source/timingProm.sv
source/beamCounter.sv
source/syncBlankGen.sv
source/videoTimingTop.sv
verif/videoTimingTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the video timing testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module videoTimingTb -Mdir obj_dir -o simv

# The result is taken from the log
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
